// ==== decode_stage.sv ====
// decode stage for a two-slot pair
// the input latch is the fetch/decode register, it holds while stalled
// take_branch is combinational from the latch and gated by get_next_inst
// only unconditional br redirects, conditional branches are not decoded
// halted is sticky until reset and blocks every later valid output
// payload registers carry no reset, only the valids and halted do

`default_nettype none

`include "fetch_params.svh"

module decode_stage
  import fetch_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  get_next_inst,   // advance level, low freezes the stage
  input  logic [`NUM_SUPER-1:0] if_valid,
  input  inst_pair_t            if_ir,
  input  pc_pair_t              if_npc,
  output logic                  take_branch,     // redirect pulse to fetch
  output logic [`ADDR_W-1:0]    branch_target,
  output logic                  halted,
  output logic [`NUM_SUPER-1:0] id_valid,
  output inst_pair_t            id_ir,
  output pc_pair_t              id_npc,
  output imm_pair_t             id_imm,
  output reg_pair_t             id_dest_reg
);

  // latched pair from fetch
  logic [`NUM_SUPER-1:0] lat_valid;
  inst_pair_t            lat_ir;
  pc_pair_t              lat_npc;

  // per-slot decode results
  logic [`NUM_SUPER-1:0] is_br;
  logic [`NUM_SUPER-1:0] is_halt;
  imm_pair_t             slot_imm;
  reg_pair_t             slot_dest;

  logic [`NUM_SUPER-1:0] keep;      // slots that survive squashing
  logic [`NUM_SUPER-1:0] br_hit;
  logic [`NUM_SUPER-1:0] halt_hit;
  logic                  br_slot;   // which slot redirects, 0 has priority

  ////////////////////////////////////////////////////////////////////////////
  // fetch/decode latch
  ////////////////////////////////////////////////////////////////////////////

  // fetch already drops its valids while the memory is busy
  // a redirect flushes the wrong-path pair sitting on the fetch outputs
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      lat_valid <= '0;
    end
    else if (get_next_inst)
    begin
      lat_valid <= take_branch ? '0 : if_valid;
    end
  end

  always_ff @(posedge clock)
  begin
    if (get_next_inst)
    begin
      lat_ir  <= if_ir;
      lat_npc <= if_npc;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // per-slot decode
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `NUM_SUPER; i++)
  begin : g_slot
    assign is_br[i]   = (lat_ir[i].br.opcode == `OP_BR);
    assign is_halt[i] = (lat_ir[i] == `HALT_WORD);    // whole word compare

    always_comb
    begin
      case (lat_ir[i].mem.opcode)
        `OP_BR:
        begin
          // word displacement, scale by 4 then sign-extend
          slot_imm[i]  = {{(`ADDR_W-23){lat_ir[i].br.disp[20]}}, lat_ir[i].br.disp, 2'b00};
          slot_dest[i] = lat_ir[i].br.ra;           // link register
        end
        `OP_LDQ:
        begin
          slot_imm[i]  = {{(`ADDR_W-16){lat_ir[i].mem.disp[15]}}, lat_ir[i].mem.disp};
          slot_dest[i] = lat_ir[i].mem.ra;          // load writes ra
        end
        `OP_STQ:
        begin
          slot_imm[i]  = {{(`ADDR_W-16){lat_ir[i].mem.disp[15]}}, lat_ir[i].mem.disp};
          slot_dest[i] = `ZERO_REG;                 // store writes nothing
        end
        default:
        begin
          slot_imm[i]  = '0;
          slot_dest[i] = `ZERO_REG;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // squash, branch and halt
  ////////////////////////////////////////////////////////////////////////////

  // slot 1 is younger, it dies behind a branch or halt in slot 0
  assign keep[0] = lat_valid[0];
  assign keep[1] = lat_valid[1] && !(lat_valid[0] && (is_br[0] || is_halt[0]));

  assign br_hit   = keep & is_br;
  assign halt_hit = keep & is_halt;

  // no redirect while stalled, the latch still holds the branch for later
  assign take_branch = get_next_inst && !halted && (|br_hit);

  assign br_slot = !br_hit[0];

  // npc of the branch is pc+4, target is relative to that
  assign branch_target = lat_npc[br_slot] + slot_imm[br_slot];

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      id_valid <= '0;
      halted   <= 1'b0;
    end
    else if (get_next_inst)
    begin
      id_valid <= halted ? '0 : keep;   // nothing leaves once halted
      if (|halt_hit)
      begin
        halted <= 1'b1;                 // sticky until reset
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (get_next_inst)
    begin
      id_ir       <= lat_ir;
      id_npc      <= lat_npc;
      id_imm      <= slot_imm;
      id_dest_reg <= slot_dest;
    end
  end

endmodule

`default_nettype wire

// ==== fetch_params.svh ====
// shared constants for the two-way fetch/decode front end
// slot count is fixed at two because the next-PC rule only handles +4 or +8
// opcodes follow the alpha encoding, bits 31:26 of the instruction word
// halt is one whole 32-bit word and is not matched on the opcode alone

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// machine shape
////////////////////////////////////////////////////////////////////////////

`define NUM_SUPER 2             // slots per 64-bit fetch line
`define ADDR_W    64            // pc and address width

////////////////////////////////////////////////////////////////////////////
// instruction encodings
////////////////////////////////////////////////////////////////////////////

`define OP_BR     6'h30         // unconditional branch, br format
`define OP_LDQ    6'h29         // load quad, mem format
`define OP_STQ    6'h2d         // store quad, mem format

// call_pal halt
`define HALT_WORD 32'h0000_0555

`define ZERO_REG  5'd31         // r31 reads as zero, used as "no destination"

`endif

// ==== fetch_pipe_assertions.sv ====
// protocol checks on the fetch front end, bound into fetch_pipe_top
// all properties are off while reset is high

`default_nettype none

`include "fetch_params.svh"

module fetch_pipe_assertions (
  input logic                  clock,
  input logic                  reset,
  input logic                  get_next_inst,
  input logic                  imem_valid,
  input logic                  take_branch,
  input logic                  halted,
  input logic [`ADDR_W-1:0]    proc2imem_addr,
  input logic [`NUM_SUPER-1:0] id_valid
);

  // the memory needs the line address held until it answers
  addr_held: assert property (@(posedge clock) disable iff (reset)
    (!imem_valid && !take_branch) |=> $stable(proc2imem_addr))
    else $error("line address moved before the memory answered");

  // the latch flushes behind a redirect so it fires only once
  branch_pulse: assert property (@(posedge clock) disable iff (reset)
    take_branch |=> !take_branch)
    else $error("take_branch stayed high for more than one cycle");

  // the halt pair itself may still be on the outputs, nothing after it
  quiet_after_halt: assert property (@(posedge clock) disable iff (reset)
    (halted && get_next_inst) |=> (id_valid == '0))
    else $error("valid output slot after halt");

endmodule

bind fetch_pipe_top fetch_pipe_assertions chk (
  .clock          (clock),
  .reset          (reset),
  .get_next_inst  (get_next_inst),
  .imem_valid     (imem_valid),
  .take_branch    (take_branch),        // internal decode-to-fetch pulse
  .halted         (halted),
  .proc2imem_addr (proc2imem_addr),
  .id_valid       (id_valid)
);

`default_nettype wire

// ==== fetch_pipe_top.sv ====
// fetch and decode front end for a two-way machine
// the instruction memory sits outside and may take several cycles per line
// get_next_inst is the only back-pressure, a low level freezes the pipe
// decoded pairs leave one edge after the latch takes them from fetch

`default_nettype none

`include "fetch_params.svh"

module fetch_pipe_top
  import fetch_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  get_next_inst,   // downstream ready level
  input  logic                  imem_valid,      // memory answer ready
  input  inst_pair_t            imem2proc_data,  // one aligned line
  output logic [`ADDR_W-1:0]    proc2imem_addr,
  output logic [`NUM_SUPER-1:0] id_valid,
  output inst_pair_t            id_ir,
  output pc_pair_t              id_npc,
  output imm_pair_t             id_imm,
  output reg_pair_t             id_dest_reg,
  output logic                  halted
);

  ////////////////////////////////////////////////////////////////////////////
  // fetch to decode
  ////////////////////////////////////////////////////////////////////////////

  logic [`NUM_SUPER-1:0] if_valid;
  inst_pair_t            if_ir;
  pc_pair_t              if_npc;

  // decode back to fetch
  logic                  take_branch;
  logic [`ADDR_W-1:0]    branch_target;

  fetch_stage u_fetch (
    .clock          (clock),
    .reset          (reset),
    .get_next_inst  (get_next_inst),
    .take_branch    (take_branch),
    .branch_target  (branch_target),
    .imem_valid     (imem_valid),
    .halted         (halted),           // stops the pc
    .imem2proc_data (imem2proc_data),
    .proc2imem_addr (proc2imem_addr),
    .if_ir          (if_ir),
    .if_npc         (if_npc),
    .if_valid       (if_valid)
  );

  decode_stage u_decode (
    .clock          (clock),
    .reset          (reset),
    .get_next_inst  (get_next_inst),
    .if_valid       (if_valid),
    .if_ir          (if_ir),
    .if_npc         (if_npc),
    .take_branch    (take_branch),
    .branch_target  (branch_target),
    .halted         (halted),
    .id_valid       (id_valid),
    .id_ir          (id_ir),
    .id_npc         (id_npc),
    .id_imm         (id_imm),
    .id_dest_reg    (id_dest_reg)
  );

endmodule

`default_nettype wire

// ==== fetch_pkg.sv ====
// types shared by fetch and decode
// inst_u gives two views of one instruction word, mem format and br format
// all pair types are packed with slot 0 in the low bits, matching the
// memory line where slot 0 is the word at the lower address

`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // instruction word views
  ////////////////////////////////////////////////////////////////////////////

  // memory format, ldq / stq
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;            // data register
    logic [4:0]  rb;            // base register
    logic [15:0] disp;          // signed byte displacement
  } inst_mem_t;

  // branch format
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;            // link register
    logic [20:0] disp;          // signed word displacement
  } inst_br_t;

  // one 32-bit word read either way
  typedef union packed {
    inst_mem_t mem;
    inst_br_t  br;
  } inst_u;

  ////////////////////////////////////////////////////////////////////////////
  // per-slot vectors, index 0 is the older slot
  ////////////////////////////////////////////////////////////////////////////

  typedef inst_u [`NUM_SUPER-1:0]              inst_pair_t;  // 64 bits
  typedef logic  [`NUM_SUPER-1:0][`ADDR_W-1:0] pc_pair_t;    // 128 bits
  typedef logic  [`NUM_SUPER-1:0][`ADDR_W-1:0] imm_pair_t;   // sign-extended immediates
  typedef logic  [`NUM_SUPER-1:0][4:0]         reg_pair_t;   // register numbers

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
// fetch stage, holds the pc and splits each 64-bit memory line in two
// memory data is only trusted while imem_valid is high
// the line address stays put until the pc moves, the memory relies on that
// a taken branch moves the pc even during a stall, halted freezes it
// pc resets to 0

`default_nettype none

`include "fetch_params.svh"

module fetch_stage
  import fetch_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  logic               get_next_inst,    // downstream ready level
  input  logic               take_branch,      // one-cycle redirect from decode
  input  logic [`ADDR_W-1:0] branch_target,
  input  logic               imem_valid,       // memory line is ready
  input  logic               halted,           // sticky halt from decode
  input  inst_pair_t         imem2proc_data,
  output logic [`ADDR_W-1:0] proc2imem_addr,
  output inst_pair_t         if_ir,
  output pc_pair_t           if_npc,
  output logic [`NUM_SUPER-1:0] if_valid
);

  logic [`ADDR_W-1:0] pc_reg;       // pc being fetched
  logic [`ADDR_W-1:0] pc_plus;      // sequential successor of the line
  logic [`ADDR_W-1:0] next_pc;
  logic               pc_enable;
  logic               upper_half;   // pc points at the second word of the line

  ////////////////////////////////////////////////////////////////////////////
  // address and slot split
  ////////////////////////////////////////////////////////////////////////////

  assign upper_half = pc_reg[2];

  // memory is addressed by line, low three bits dropped
  assign proc2imem_addr = {pc_reg[`ADDR_W-1:3], 3'b000};

  // slot 0 is the word at the lower address
  assign if_ir[0] = imem2proc_data[0];
  assign if_ir[1] = imem2proc_data[1];

  ////////////////////////////////////////////////////////////////////////////
  // next pc
  ////////////////////////////////////////////////////////////////////////////

  // upper half only fetches one word, lower half fetches both
  assign pc_plus = upper_half ? (pc_reg + `ADDR_W'(4))
                              : (pc_reg + `ADDR_W'(4 * `NUM_SUPER));

  assign next_pc = take_branch ? branch_target : pc_plus;

  // the branch must win over a stall, otherwise the redirect is lost
  // since decode only pulses it for one cycle
  assign pc_enable = take_branch || (imem_valid && get_next_inst && !halted);

  // npc travels with each slot
  // an invalid slot 0 just carries the pc, nobody looks at it
  assign if_npc[0] = upper_half ? pc_reg : (pc_reg + `ADDR_W'(4));
  assign if_npc[1] = pc_plus;

  ////////////////////////////////////////////////////////////////////////////
  // slot valids
  ////////////////////////////////////////////////////////////////////////////

  assign if_valid[0] = imem_valid && !upper_half;   // lower word skipped after a jump into upper half
  assign if_valid[1] = imem_valid;

  ////////////////////////////////////////////////////////////////////////////
  // pc register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc_reg <= '0;                 // boot from address 0
    end
    else if (pc_enable)
    begin
      pc_reg <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
fetch_pkg.sv
fetch_stage.sv
decode_stage.sv
fetch_pipe_top.sv
tb_imem_model.sv
fetch_pipe_assertions.sv
tb_fetch_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_fetch_pipe -o sim_fetch_pipe > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_fetch_pipe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "testbench reported failure"
  exit 1
fi

exit 0

// ==== tb_fetch_pipe.sv ====
// testbench for the fetch/decode front end
// each test writes a program, builds the expected slot stream and runs to halt
// every program must end in a halt, the run waits for halted to rise
// an output slot counts as taken at an edge where get_next_inst is high

`default_nettype none

`include "fetch_params.svh"

module tb_fetch_pipe
  import fetch_pkg::*;
();

  localparam int MAX_LAT     = 3;         // worst memory wait per line
  localparam int TOTAL_WORDS = 90;        // all programs, wrong-path fetches included
  localparam int CYCLE_LIMIT = 6 * 30 + 8 * TOTAL_WORDS * (MAX_LAT + 1);

  logic                  clock;
  logic                  reset;
  logic                  get_next_inst;
  logic                  imem_valid;
  inst_pair_t            imem2proc_data;
  logic [`ADDR_W-1:0]    proc2imem_addr;
  logic [`NUM_SUPER-1:0] id_valid;
  inst_pair_t            id_ir;
  pc_pair_t              id_npc;
  imm_pair_t             id_imm;
  reg_pair_t             id_dest_reg;
  logic                  halted;

  logic [31:0] code [0:255];              // program by word address
  logic [63:0] exp_npc [$];
  inst_u       exp_inst [$];
  logic [63:0] exp_imm [$];
  logic [4:0]  exp_reg [$];
  logic [31:0] lfsr_state;
  logic        random_stall;
  int          errors;
  int          checks;
  int          cycles;

  fetch_pipe_top uut (
    .clock          (clock),
    .reset          (reset),
    .get_next_inst  (get_next_inst),
    .imem_valid     (imem_valid),
    .imem2proc_data (imem2proc_data),
    .proc2imem_addr (proc2imem_addr),
    .id_valid       (id_valid),
    .id_ir          (id_ir),
    .id_npc         (id_npc),
    .id_imm         (id_imm),
    .id_dest_reg    (id_dest_reg),
    .halted         (halted)
  );

  tb_imem_model mem (
    .clock (clock),
    .reset (reset),
    .addr  (proc2imem_addr),
    .valid (imem_valid),
    .data  (imem2proc_data)
  );

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random bits and instruction encoding
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
    begin
      n = n ^ 32'hD000_0001;
    end
    return n;
  endfunction

  task automatic take_bit(output logic b);
    b          = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  endtask

  function automatic logic [31:0] enc_mem(input logic [5:0] op, input logic [4:0] ra,
                                          input logic [4:0] rb, input logic [15:0] disp);
    return {op, ra, rb, disp};
  endfunction

  // br at byte address at, jumping to byte address target
  function automatic logic [31:0] br_to(input logic [4:0] ra, input int at, input int target);
    int words;
    words = (target - (at + 4)) / 4;
    return {`OP_BR, ra, 21'(words)};
  endfunction

  // immediate as the isa defines it
  function automatic logic [63:0] imm_of_word(input logic [31:0] w);
    logic signed [63:0] v;
    v = '0;
    if (w[31:26] == `OP_BR)
    begin
      v = 64'($signed(w[20:0])) * 64'sd4;   // word displacement
    end
    else if (w[31:26] == `OP_LDQ || w[31:26] == `OP_STQ)
    begin
      v = 64'($signed(w[15:0]));            // byte displacement
    end
    return v;
  endfunction

  function automatic logic [4:0] dest_of_word(input logic [31:0] w);
    if (w[31:26] == `OP_BR || w[31:26] == `OP_LDQ)
    begin
      return w[25:21];
    end
    return `ZERO_REG;
  endfunction

  // unused words carry their own byte address, opcode 0x10 decodes as nothing
  task automatic fill_code();
    for (int i = 0; i < 256; i++)
    begin
      code[i] = {6'h10, 26'(i * 4)};
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model, walks the program slot by slot
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_expected();
    logic [63:0] pc;
    logic [63:0] a;
    logic [63:0] last;
    logic [31:0] w;
    logic        done;
    logic        moved;
    int          guard;
    exp_npc.delete();
    exp_inst.delete();
    exp_imm.delete();
    exp_reg.delete();
    pc    = '0;
    done  = 1'b0;
    guard = 0;
    while (!done && guard < 200)
    begin
      last  = pc[2] ? pc : pc + 64'd4;      // upper half fetches one word
      a     = pc;
      moved = 1'b0;
      while (!moved && a <= last)
      begin
        w = code[a[9:2]];
        exp_npc.push_back(a + 64'd4);
        exp_inst.push_back(w);
        exp_imm.push_back(imm_of_word(w));
        exp_reg.push_back(dest_of_word(w));
        if (w[31:26] == `OP_BR)
        begin
          pc    = a + 64'd4 + imm_of_word(w);
          moved = 1'b1;                     // younger slot is dropped
        end
        else if (w == `HALT_WORD)
        begin
          done  = 1'b1;
          moved = 1'b1;
        end
        a = a + 64'd4;
      end
      if (!moved)
      begin
        pc = last + 64'd4;
      end
      guard++;
    end
  endtask

  task automatic load_program();
    for (int l = 0; l < 128; l++)
    begin
      mem.prog[l] = {code[2 * l + 1], code[2 * l]};   // slot 0 in the low word
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_inst(input inst_u got, input inst_u exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: instruction %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic compare_pc(input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: npc %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic compare_imm(input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: immediate %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic compare_reg(input logic [4:0] got, input logic [4:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: dest reg %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic compare_halted(input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: halted %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_slot(input int i, output logic was_halt);
    logic [63:0] exp_pc;
    inst_u       exp_w;
    was_halt = 1'b0;
    if (exp_npc.size() == 0)
    begin
      errors++;
      $display("unexpected valid output in slot %0d at time %0t", i, $time);
    end
    else
    begin
      exp_pc   = exp_npc.pop_front();
      exp_w    = exp_inst.pop_front();
      was_halt = (exp_w == `HALT_WORD);
      // lower word of a line leaves in slot 0, its npc sits in the upper half
      checks++;
      if (i != (exp_pc[2] ? 0 : 1))
      begin
        errors++;
        $display("** Error at %0t: word at %h came out in slot %0d",
                 $time, exp_pc - 64'd4, i);
      end
      compare_pc(id_npc[i], exp_pc);
      compare_inst(id_ir[i], exp_w);
      compare_imm(id_imm[i], exp_imm.pop_front());
      compare_reg(id_dest_reg[i], exp_reg.pop_front());
    end
  endtask

  // outputs are stable mid-cycle and the stall level for the next edge is set
  always @(negedge clock)
  begin : monitor
    logic pair_halt;
    logic slot_halt;
    logic any_valid;
    if (!reset && get_next_inst)
    begin
      pair_halt = 1'b0;
      any_valid = 1'b0;
      for (int i = 0; i < `NUM_SUPER; i++)
      begin
        if (id_valid[i])
        begin
          check_slot(i, slot_halt);
          pair_halt = pair_halt | slot_halt;
          any_valid = 1'b1;
        end
      end
      if (any_valid)
      begin
        compare_halted(halted, pair_halt);   // rises with the pair holding the halt
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock)
  begin : drive_stall
    logic b;
    #1;
    if (random_stall)
    begin
      take_bit(b);
      get_next_inst = b;                  // half the cycles stall
    end
    else
    begin
      get_next_inst = 1'b1;
    end
  end

  always @(posedge clock)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout, run went past %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic apply_reset();
    @(posedge clock);
    #1;
    reset = 1'b1;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
  endtask

  task automatic run_program(input logic stalls);
    build_expected();
    load_program();
    random_stall = 1'b0;
    apply_reset();
    @(negedge clock);
    random_stall = stalls;
    while (!halted)
    begin
      @(negedge clock);
    end
    random_stall = 1'b0;
    repeat (4) @(negedge clock);          // lets the halt pair drain out
    if (exp_npc.size() != 0)
    begin
      errors++;
      $display("%0d expected slots never appeared by time %0t", exp_npc.size(), $time);
    end
  endtask

  // straight line code ending in a halt in slot 1
  task automatic sequential_fetch();
    fill_code();
    for (int i = 0; i < 13; i++)
    begin
      code[i] = enc_mem(`OP_LDQ, 5'(i), 5'd30, 16'(8 * i));
    end
    code[13] = `HALT_WORD;
    run_program(1'b0);
  endtask

  task automatic branch_program();
    fill_code();
    code[0]  = enc_mem(`OP_LDQ, 5'd1, 5'd30, 16'h0010);
    code[1]  = br_to(5'd26, 'h04, 'h44);  // slot 1, forward into upper half
    code[17] = enc_mem(`OP_LDQ, 5'd2, 5'd30, 16'h0020);
    code[18] = br_to(5'd31, 'h48, 'h14);  // slot 0, backward
    code[19] = enc_mem(`OP_LDQ, 5'd3, 5'd30, 16'h0030);   // wrong path
    code[5]  = enc_mem(`OP_STQ, 5'd4, 5'd30, 16'hfff0);
    code[6]  = br_to(5'd27, 'h18, 'h80);  // slot 0, forward
    code[32] = enc_mem(`OP_LDQ, 5'd5, 5'd29, 16'h0008);
    code[33] = `HALT_WORD;
  endtask

  task automatic branch_redirects();
    branch_program();
    run_program(1'b0);
  endtask

  task automatic immediate_decode();
    fill_code();
    code[0]  = enc_mem(`OP_LDQ, 5'd4, 5'd30, 16'hfff8);
    code[1]  = enc_mem(`OP_STQ, 5'd5, 5'd30, 16'h8000);
    code[2]  = enc_mem(`OP_LDQ, 5'd31, 5'd2, 16'h7fff);
    code[3]  = {6'h11, 5'd7, 5'd8, 16'hffff};             // other opcode
    code[4]  = br_to(5'd9, 'h10, 'h100);
    code[64] = enc_mem(`OP_STQ, 5'd6, 5'd1, 16'h0123);
    code[65] = `HALT_WORD;
    run_program(1'b0);
  endtask

  task automatic stall_sequences();
    branch_program();
    run_program(1'b1);
    straight_line_with_stalls();
  endtask

  task automatic straight_line_with_stalls();
    fill_code();
    for (int i = 0; i < 9; i++)
    begin
      code[i] = enc_mem(`OP_STQ, 5'(i), 5'd1, 16'(-4 * i));
    end
    code[9] = `HALT_WORD;
    run_program(1'b1);
  endtask

  // halt in slot 0 drops slot 1 and a reset then restarts at pc 0
  task automatic halt_and_restart();
    fill_code();
    code[0] = enc_mem(`OP_LDQ, 5'd1, 5'd30, 16'h0000);
    code[1] = enc_mem(`OP_STQ, 5'd2, 5'd30, 16'h0008);
    code[2] = `HALT_WORD;
    code[3] = enc_mem(`OP_LDQ, 5'd3, 5'd30, 16'h0010);
    run_program(1'b0);
    code[2] = enc_mem(`OP_LDQ, 5'd3, 5'd30, 16'h0018);
    code[3] = `HALT_WORD;                 // now in slot 1
    code[4] = enc_mem(`OP_LDQ, 5'd6, 5'd30, 16'h0020);
    run_program(1'b1);
  endtask

  initial
  begin
    reset         = 1'b1;
    get_next_inst = 1'b1;
    random_stall  = 1'b0;
    lfsr_state    = 32'd68116;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    sequential_fetch();
    branch_redirects();
    immediate_decode();
    stall_sequences();
    halt_and_restart();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_imem_model.sv ====
// instruction memory model for the fetch front end testbench
// program is held per 64-bit line, 128 lines, the testbench writes prog directly
// a new line address waits 0 to 3 cycles before valid rises
// latency comes from a galois lfsr, two bits taken per new address
// valid stays high while the address holds, data follows the address

`default_nettype none

`include "fetch_params.svh"

module tb_imem_model
  import fetch_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  logic [`ADDR_W-1:0] addr,        // aligned line address from fetch
  output logic               valid,
  output inst_pair_t         data
);

  logic [63:0]        prog [0:127];       // one entry per line
  logic [31:0]        lfsr_state;
  logic [`ADDR_W-1:0] last_addr;          // address the current wait belongs to
  logic [1:0]         wait_left;

  // right-shift galois form, taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
    begin
      n = n ^ 32'hD000_0001;
    end
    return n;
  endfunction

  task automatic take_bit(output logic b);
    b          = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  endtask

  assign data = prog[addr[9:3]];

  initial
  begin
    valid      = 1'b0;
    lfsr_state = 32'd68116;
    last_addr  = '1;
    wait_left  = 2'd0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // latency per line request
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock)
  begin : respond
    logic was_reset;
    logic b0;
    logic b1;
    was_reset = reset;                    // value the dut saw at this edge
    #1;                                   // pc has settled by now
    if (was_reset)
    begin
      valid     = 1'b0;
      last_addr = '1;                     // forces a fresh draw after reset
    end
    else if (addr != last_addr)
    begin
      take_bit(b0);
      take_bit(b1);
      wait_left = {b1, b0};
      last_addr = addr;
      valid     = (wait_left == 2'd0);
    end
    else if (!valid)
    begin
      wait_left = wait_left - 2'd1;
      valid     = (wait_left == 2'd0);
    end
  end

endmodule

`default_nettype wire
